// File: cart_loader_top.f
+incdir+include
rtl/cart_pkg.sv
rtl/cart_apb_port.sv
rtl/region_detect.sv
rtl/cart_quirk_match.sv
rtl/cheat_code_loader.sv
rtl/cart_loader_top.sv
verif/cart_loader_tb.sv

// File: include/cart_loader_settings.svh
`ifndef CART_LOADER_SETTINGS_SVH
`define CART_LOADER_SETTINGS_SVH

//////////////////////////////////////////////////
// Download stream widths
//////////////////////////////////////////////////
`define CART_ADDR_W         25      // Byte address of the image
`define CART_DATA_W         16

// APB port
`define APB_ADDR_W          12
`define APB_DATA_W          32

//////////////////////////////////////////////////
// Cartridge header offsets
//////////////////////////////////////////////////
`define HDR_REGION_ADDR0    'h1F0   // Two region letters
`define HDR_REGION_ADDR1    'h1F2   // Low byte only
`define HDR_READY_ADDR      'h200   // Header complete
`define CART_ID_ADDR_FIRST  'h182
`define CART_ID_ADDR_LAST   'h18A
`define CART_ID_MATCH_ADDR  'h18C   // Product code lookup
`define CHEAT_LAST_OFS      4'hE    // Last slot of a cheat record

`define GUN_DELAY_DEFAULT   44

// Register offsets
`define REG_CTRL            'h00
`define REG_ADDR            'h04
`define REG_DATA            'h08
`define REG_STATUS          'h0C
`define REG_GUN             'h10

`endif

// File: rtl/cart_apb_port.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module cart_apb_port (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  cart_pkg::apb_req_t      apb_req,
	output cart_pkg::apb_rsp_t      apb_rsp,
	input  logic                    rom_ack,
	output logic                    rom_req,
	output logic [`CART_ADDR_W-1:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_data,
	output cart_pkg::dl_word_t      dl,
	output logic                    dl_valid,
	input  cart_pkg::region_t       region,
	input  logic                    region_valid,
	input  cart_pkg::quirk_flags_t  quirks,
	input  cart_pkg::gun_cfg_t      gun_cfg,
	input  logic [7:0]              cheat_count,
	output cart_pkg::region_policy_t policy,
	output logic                    auto_region,
	output cart_pkg::region_t       manual_region
);
	import cart_pkg::*;

	localparam logic [`CART_ADDR_W-1:0] ADDR_STEP = 2;  // One 16-bit word

	ctrl_reg_t               ctrl;
	ctrl_reg_t               ctrl_wr;
	logic [`CART_ADDR_W-1:0] addr_cnt;
	logic                    first_pending;
	status_t                 status;
	logic                    access, wr_done, cart_stall;
	logic                    hit_ctrl, hit_addr, hit_data, hit_status, hit_gun;
	logic                    data_emit, last_emit, dl_start;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	assign hit_ctrl   = apb_req.paddr == `REG_CTRL;
	assign hit_addr   = apb_req.paddr == `REG_ADDR;
	assign hit_data   = apb_req.paddr == `REG_DATA;
	assign hit_status = apb_req.paddr == `REG_STATUS;
	assign hit_gun    = apb_req.paddr == `REG_GUN;

	assign access  = apb_req.psel & apb_req.penable;
	assign ctrl_wr = ctrl_reg_t'(apb_req.pwdata[$bits(ctrl_reg_t)-1:0]);

	// Hold the host while the previous ROM write is still in flight
	assign cart_stall = access & apb_req.pwrite & hit_data & ctrl.cart_dl & (rom_req != rom_ack);
	assign wr_done    = access & apb_req.pwrite & ~cart_stall;

	assign data_emit = wr_done & hit_data & (ctrl.cart_dl | ctrl.code_dl);
	assign last_emit = wr_done & hit_ctrl & ctrl.cart_dl & ~ctrl_wr.cart_dl;
	assign dl_start  = wr_done & hit_ctrl & ((ctrl_wr.cart_dl & ~ctrl.cart_dl) |
		(ctrl_wr.code_dl & ~ctrl.code_dl));

	assign status = '{cheat_count: cheat_count, quirks: quirks, rsvd: '0,
		region_valid: region_valid, region: region};

	always_comb begin
		apb_rsp         = '0;
		apb_rsp.pready  = ~cart_stall;
		apb_rsp.pslverr = access & ~(hit_ctrl | hit_addr | hit_data | hit_status | hit_gun);
		if (hit_ctrl) apb_rsp.prdata[$bits(ctrl_reg_t)-1:0] = ctrl;
		else if (hit_addr) apb_rsp.prdata[`CART_ADDR_W-1:0] = addr_cnt;
		else if (hit_status) apb_rsp.prdata[$bits(status_t)-1:0] = status;
		else if (hit_gun) apb_rsp.prdata[$bits(gun_cfg_t)-1:0] = gun_cfg;
	end

	//////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ctrl          <= '0;
			addr_cnt      <= '0;
			first_pending <= 1'b0;
			rom_req       <= 1'b0;
			dl_valid      <= 1'b0;
		end else begin
			dl_valid <= data_emit | last_emit;
			if (wr_done & hit_ctrl) ctrl <= ctrl_wr;
			if (dl_start) first_pending <= 1'b1;
			else if (data_emit) first_pending <= 1'b0;
			if (wr_done & hit_addr) addr_cnt <= apb_req.pwdata[`CART_ADDR_W-1:0];
			else if (data_emit) addr_cnt <= addr_cnt + ADDR_STEP;
			if (data_emit & ctrl.cart_dl) rom_req <= ~rom_req;  // Toggle request
		end
	end

	// Word payload
	always_ff @(posedge clk_sys) begin
		if (data_emit) begin
			dl <= '{addr: addr_cnt, data: apb_req.pwdata[`CART_DATA_W-1:0],
				cart: ctrl.cart_dl, code: ctrl.code_dl & ~ctrl.cart_dl,
				first: first_pending, last: 1'b0};
		end else if (last_emit) begin
			dl <= '{addr: addr_cnt - ADDR_STEP, data: '0, cart: 1'b0, code: 1'b0,
				first: 1'b0, last: 1'b1};
		end
		if (data_emit & ctrl.cart_dl) begin
			rom_addr <= addr_cnt;
			rom_data <= apb_req.pwdata[`CART_DATA_W-1:0];
		end
	end

	assign policy        = ctrl.policy;
	assign auto_region   = ctrl.auto_region;
	assign manual_region = ctrl.manual_region;

endmodule

`default_nettype wire

// File: rtl/cart_loader_top.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  cart_pkg::apb_req_t      apb_req,
	output cart_pkg::apb_rsp_t      apb_rsp,
	output logic                    rom_req,
	input  logic                    rom_ack,
	output logic [`CART_ADDR_W-1:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_data,
	output cart_pkg::cheat_code_u   cheat,
	output logic                    cheat_valid
);
	import cart_pkg::*;

	// Download stream, one writer and three observers
	dl_word_t       dl;
	logic           dl_valid;
	region_t        region;
	logic           region_valid;
	quirk_flags_t   quirks;
	gun_cfg_t       gun_cfg;
	logic [7:0]     cheat_count;
	region_policy_t policy;
	logic           auto_region;
	region_t        manual_region;

	cart_apb_port apb_port_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.rom_ack(rom_ack), .rom_req(rom_req), .rom_addr(rom_addr), .rom_data(rom_data),
		.dl(dl), .dl_valid(dl_valid),
		.region(region), .region_valid(region_valid), .quirks(quirks),
		.gun_cfg(gun_cfg), .cheat_count(cheat_count),
		.policy(policy), .auto_region(auto_region), .manual_region(manual_region)
	);

	region_detect region_detect_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl), .dl_valid(dl_valid),
		.policy(policy), .auto_region(auto_region), .manual_region(manual_region),
		.region(region), .region_valid(region_valid)
	);

	cart_quirk_match quirk_match_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl), .dl_valid(dl_valid),
		.quirks(quirks), .gun_cfg(gun_cfg)
	);

	cheat_code_loader cheat_loader_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl), .dl_valid(dl_valid),
		.cheat(cheat), .cheat_valid(cheat_valid), .cheat_count(cheat_count)
	);

endmodule

`default_nettype wire

// File: rtl/cart_pkg.sv
`default_nettype none
`include "cart_loader_settings.svh"

package cart_pkg;

	typedef struct packed {
		logic [`APB_ADDR_W-1:0] paddr;
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`APB_DATA_W-1:0] prdata;
		logic                   pready;
		logic                   pslverr;
	} apb_rsp_t;

	// One word of the download stream
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
		logic                    cart;
		logic                    code;
		logic                    first;
		logic                    last;  // Cart flag fell, addr is the last word
	} dl_word_t;

	typedef enum logic [1:0] {JP = 2'd0, US = 2'd1, EU = 2'd2} region_t;

	// Priority orders for auto-region
	typedef enum logic [1:0] {
		POL_US_EU_JP = 2'd0,
		POL_EU_US_JP = 2'd1,
		POL_US_JP_EU = 2'd2,
		POL_JP_US_EU = 2'd3
	} region_policy_t;

	// REG_CTRL bits 6:0
	typedef struct packed {
		region_t        manual_region;
		logic           auto_region;
		region_policy_t policy;
		logic           code_dl;
		logic           cart_dl;
	} ctrl_reg_t;

	typedef struct packed {
		logic sram, eeprom, noram, fifo, pier, svp, fmbusy, schan;
	} quirk_flags_t;

	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	// REG_STATUS bits 23:0
	typedef struct packed {
		logic [7:0]   cheat_count;
		quirk_flags_t quirks;
		logic [4:0]   rsvd;
		logic         region_valid;
		region_t      region;
	} status_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Loaded as word slots, consumed as fields
	typedef union packed {
		logic [7:0][15:0] word;
		cheat_fields_t    field;
	} cheat_code_u;

endpackage

`default_nettype wire

// File: rtl/cart_quirk_match.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module cart_quirk_match (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_pkg::dl_word_t     dl,
	input  logic                   dl_valid,
	output cart_pkg::quirk_flags_t quirks,
	output cart_pkg::gun_cfg_t     gun_cfg
);
	import cart_pkg::*;

	logic        cart_wr;
	logic [63:0] cart_id;  // 8 ASCII chars, first char in the top byte
	logic [15:0] swapped;

	function automatic quirk_flags_t quirk_lookup(input logic [63:0] id);
		quirk_flags_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				q.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				q.eeprom = 1'b1;
			"T-113016": q.noram = 1'b1;  // Fake RAM check
			"T-89016 ": q.fifo = 1'b1;
			"T-574023", "T-574013": q.pier = 1'b1;
			"MK-1229 ", "G-7001  ": q.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": q.fmbusy = 1'b1;
			"T-68???-": q.schan = 1'b1;  // Literal question marks in the header
			default: q = '0;
		endcase
		return q;
	endfunction

	// Light-gun device type and sensor timing
	function automatic gun_cfg_t gun_lookup(input logic [63:0] id);
		gun_cfg_t g;
		case (id)
			"MK-1533 ": g = '{gun_type: 1'b0, sensor_delay: 8'd100};
			"T-95096-": g = '{gun_type: 1'b1, sensor_delay: 8'd52};
			"T-95136-": g = '{gun_type: 1'b1, sensor_delay: 8'd30};
			"MK-1658 ": g = '{gun_type: 1'b0, sensor_delay: 8'd120};
			"T-081156": g = '{gun_type: 1'b0, sensor_delay: 8'd126};
			default:    g = '{gun_type: 1'b0, sensor_delay: 8'(`GUN_DELAY_DEFAULT)};
		endcase
		return g;
	endfunction

	assign cart_wr = dl_valid & dl.cart;
	assign swapped = {dl.data[7:0], dl.data[15:8]};

	//////////////////////////////////////////////////
	// Product code capture
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (dl.addr)
				`CART_ID_ADDR_FIRST:     cart_id[63:56] <= dl.data[15:8];  // Odd start
				`CART_ID_ADDR_FIRST + 2: cart_id[55:40] <= swapped;
				`CART_ID_ADDR_FIRST + 4: cart_id[39:24] <= swapped;
				`CART_ID_ADDR_FIRST + 6: cart_id[23:8]  <= swapped;
				`CART_ID_ADDR_LAST:      cart_id[7:0]   <= dl.data[7:0];
				default: ;
			endcase
		end
	end

	// Table lookup
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks  <= '0;
			gun_cfg <= '{gun_type: 1'b0, sensor_delay: 8'(`GUN_DELAY_DEFAULT)};
		end else if (cart_wr) begin
			if (dl.first) quirks <= '0;
			if (dl.addr == `CART_ID_MATCH_ADDR) begin
				quirks  <= quirk_lookup(cart_id);
				gun_cfg <= gun_lookup(cart_id);  // Held until the next lookup
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/cheat_code_loader.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  cart_pkg::dl_word_t    dl,
	input  logic                  dl_valid,
	output cart_pkg::cheat_code_u cheat,
	output logic                  cheat_valid,
	output logic [7:0]            cheat_count
);
	import cart_pkg::*;

	logic       code_wr;
	logic       rec_done;
	logic [2:0] slot;

	assign code_wr  = dl_valid & dl.code;
	assign rec_done = code_wr & (dl.addr[3:0] == `CHEAT_LAST_OFS);

	// Bottom word of each field comes first in the stream
	assign slot = {~dl.addr[3], ~dl.addr[2], dl.addr[1]};

	//////////////////////////////////////////////////
	// Record assembly
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (code_wr) cheat.word[slot] <= dl.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_count <= '0;
		end else begin
			cheat_valid <= rec_done;  // Replace top word closes the record
			if (rec_done) cheat_count <= cheat_count + 8'd1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/region_detect.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module region_detect (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  cart_pkg::dl_word_t       dl,
	input  logic                     dl_valid,
	input  cart_pkg::region_policy_t policy,
	input  logic                     auto_region,
	input  cart_pkg::region_t        manual_region,
	output cart_pkg::region_t        region,
	output logic                     region_valid
);
	import cart_pkg::*;

	logic       cart_wr;
	logic [2:0] hdr_flags;  // {j, u, e}
	logic [2:0] flags_base;
	logic [2:0] lo_flags, hi_flags;

	// Classify one header character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		if (c == "J") return 3'b100;
		else if (c == "U") return 3'b010;
		else if (c >= "0" && c <= "Z") return 3'b001;
		return 3'b000;
	endfunction

	// First flag found in policy order, else the policy's first region
	function automatic region_t resolve(input region_policy_t pol, input logic [2:0] f);
		logic    j, u, e;
		region_t r;
		{j, u, e} = f;
		case (pol)
			POL_US_EU_JP: r = u ? US : e ? EU : j ? JP : US;
			POL_EU_US_JP: r = e ? EU : u ? US : j ? JP : EU;
			POL_US_JP_EU: r = u ? US : j ? JP : e ? EU : US;
			default:      r = j ? JP : u ? US : e ? EU : JP;
		endcase
		return r;
	endfunction

	assign cart_wr    = dl_valid & dl.cart;
	assign lo_flags   = letter_flags(dl.data[7:0]);
	assign hi_flags   = letter_flags(dl.data[15:8]);
	assign flags_base = dl.first ? 3'b000 : hdr_flags;  // New download starts clean

	//////////////////////////////////////////////////
	// Header scan
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_flags    <= '0;
			region       <= JP;
			region_valid <= 1'b0;
		end else if (cart_wr) begin
			if (dl.first) begin
				hdr_flags    <= '0;
				region_valid <= 1'b0;
			end
			if (dl.addr == `HDR_REGION_ADDR0) hdr_flags <= flags_base | lo_flags | hi_flags;
			else if (dl.addr == `HDR_REGION_ADDR1) hdr_flags <= flags_base | lo_flags;

			if (dl.addr == `HDR_READY_ADDR) begin
				region_valid <= 1'b1;
				region       <= auto_region ? resolve(policy, hdr_flags) : manual_region;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cart loader testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal -f cart_loader_top.f \
	--top-module cart_loader_tb -o cart_loader_sim || exit 1

out="$(./obj_dir/cart_loader_sim)"
echo "$out"
grep -qx "Simulation completed successfully" <<< "$out" && exit 0 || exit 1

// File: verif/cart_loader_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "cart_loader_settings.svh"

module cart_loader_tb;
	import cart_pkg::*;

	localparam int TIMEOUT    = 100;  // Cycles allowed for any one wait
	localparam int CART_LOADS = 16;
	localparam int CHEAT_RECS = 12;
	localparam int IMG_BASE   = 'h180;
	localparam int ROM_W      = `CART_ADDR_W + `CART_DATA_W;

	logic                    clk_sys;
	logic                    RESET;
	apb_req_t                apb_req;
	apb_rsp_t                apb_rsp;
	logic                    rom_req;
	logic                    rom_ack;
	logic [`CART_ADDR_W-1:0] rom_addr;
	logic [`CART_DATA_W-1:0] rom_data;
	cheat_code_u             cheat;
	logic                    cheat_valid;

	logic [7:0]       img [0:'h203];  // Low byte of each word sits at the even address
	logic [ROM_W-1:0] rom_expect [$];  // {addr, data} still owed to the ROM port
	logic             cart_mode;
	int               err_cnt = 0;
	int               check_cnt = 0;
	int               stall_cnt = 0;
	int               pulse_cnt = 0;

	//////////////////////////////////////////////////
	// Reference tables
	//////////////////////////////////////////////////
	logic [63:0] quirk_id [24] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ", "MK-1215 ",
		"G-4060  ", "00001211", "MK-1228 ", "G-5538  ", "00004076", "T-12046 ",
		"T-12053 ", "G-4524  ", "T-113016", "T-89016 ", "T-574023", "T-574013",
		"MK-1229 ", "G-7001  ", "T-35036 ", "T-25073 ", "MK-1137-", "T-68???-"};
	logic [7:0] quirk_bit [24] = '{  // sram is the top bit, schan the bottom
		8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40,
		8'h40, 8'h40, 8'h20, 8'h10, 8'h08, 8'h08, 8'h04, 8'h04, 8'h02, 8'h02, 8'h02, 8'h01};
	logic [63:0] gun_id [5] = '{"MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"};
	logic [8:0]  gun_val [5] = '{{1'b0, 8'd100}, {1'b1, 8'd52}, {1'b1, 8'd30},
		{1'b0, 8'd120}, {1'b0, 8'd126}};  // {type, delay}

	cart_loader_top dut_i (
		.clk_sys(clk_sys), .RESET(RESET), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.rom_req(rom_req), .rom_ack(rom_ack), .rom_addr(rom_addr), .rom_data(rom_data),
		.cheat(cheat), .cheat_valid(cheat_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (cheat_valid) pulse_cnt++;  // Doubled or stray strobes show in the count
	end

	//////////////////////////////////////////////////
	// Reporting and compare tasks
	//////////////////////////////////////////////////
	task automatic finish_run();
		$display("Checks %0d, errors %0d, ROM stalls %0d", check_cnt, err_cnt, stall_cnt);
		if (err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		err_cnt++;
		$display("Timed out waiting for %s", what);
		finish_run();
	endtask

	task automatic check_region(input logic got_valid, input region_t got,
			input logic exp_valid, input region_t exp);
		check_cnt++;
		if (got_valid !== exp_valid) begin
			err_cnt++;
			$display("ERR region_valid got %h expected %h", got_valid, exp_valid);
		end else if (exp_valid && got !== exp) begin
			err_cnt++;
			$display("ERR region got %h expected %h", got, exp);
		end
	endtask

	task automatic check_quirks(input quirk_flags_t got, input quirk_flags_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR quirks got %h expected %h", got, exp);
		end
	endtask

	task automatic check_gun(input gun_cfg_t got, input gun_cfg_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR gun_cfg got %h expected %h", got, exp);
		end
	endtask

	task automatic check_cheat(input cheat_code_u got, input cheat_fields_t exp);
		check_cnt++;
		if (got.field !== exp) begin
			err_cnt++;
			$display("ERR cheat got %h %h %h %h expected %h %h %h %h",
				got.field.flags, got.field.address, got.field.compare, got.field.replace,
				exp.flags, exp.address, exp.compare, exp.replace);
		end
	endtask

	task automatic check_rom_word(input logic [`CART_ADDR_W-1:0] got_addr, exp_addr,
			input logic [`CART_DATA_W-1:0] got_data, exp_data);
		check_cnt++;
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			err_cnt++;
			$display("ERR rom_addr/rom_data got %h/%h expected %h/%h",
				got_addr, got_data, exp_addr, exp_data);
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] got, exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// ROM memory model, acks each toggle after 0 to 6 cycles
	initial begin : rom_responder
		int               delay;
		logic [ROM_W-1:0] exp;
		forever begin
			@(negedge clk_sys);
			if (!RESET && rom_req !== rom_ack) begin
				if (rom_expect.size() == 0) begin
					err_cnt++;
					$display("ROM request seen with no cart word outstanding");
				end else begin
					exp = rom_expect.pop_front();
					check_rom_word(rom_addr, exp[ROM_W-1:`CART_DATA_W], rom_data,
						exp[`CART_DATA_W-1:0]);
				end
				delay = $urandom_range(0, 6);
				repeat (delay) @(posedge clk_sys);
				@(posedge clk_sys);
				rom_ack <= rom_req;
			end
		end
	end

	//////////////////////////////////////////////////
	// APB master
	//////////////////////////////////////////////////
	task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rd, output logic err);
		int   waits;
		logic cart_data;
		waits     = 0;
		cart_data = wr && addr == `REG_DATA && cart_mode;
		@(posedge clk_sys);
		apb_req.paddr   <= addr;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.pwdata  <= wdata;
		@(posedge clk_sys);
		apb_req.penable <= 1'b1;
		@(negedge clk_sys);
		while (!apb_rsp.pready) begin
			if (waits == TIMEOUT) timeout_abort("pready");
			waits++;
			@(negedge clk_sys);
		end
		if (waits > 0) stall_cnt++;
		if (cart_data && rom_req !== rom_ack) begin
			err_cnt++;
			$display("DATA write completed while the ROM acknowledge was outstanding");
		end
		rd  = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk_sys);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, addr, data, rd, err);
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] rd);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic logic [7:0] region_char();
		logic [7:0] pool [8] = '{"J", "U", "E", "A", "8", " ", "a", 8'h00};
		return pool[$urandom_range(0, 7)];
	endfunction

	function automatic region_t expect_region(input region_policy_t pol);
		region_t    order [4][3] = '{'{US, EU, JP}, '{EU, US, JP}, '{US, JP, EU}, '{JP, US, EU}};
		logic [2:0] found;
		region_t    r;
		found = '0;
		for (int a = `HDR_REGION_ADDR0; a <= `HDR_REGION_ADDR1; a++) begin
			if (img[a] == "J") found[JP] = 1'b1;
			else if (img[a] == "U") found[US] = 1'b1;
			else if (img[a] >= "0" && img[a] <= "Z") found[EU] = 1'b1;
		end
		r = order[pol][0];  // Nothing found falls back to the first in line
		for (int k = 2; k >= 0; k--) begin
			if (found[order[pol][k]]) r = order[pol][k];
		end
		return r;
	endfunction

	function automatic quirk_flags_t expect_quirks(input logic [63:0] code);
		quirk_flags_t q = '0;
		for (int i = 0; i < 24; i++) begin
			if (quirk_id[i] == code) q = quirk_flags_t'(quirk_bit[i]);
		end
		return q;
	endfunction

	function automatic gun_cfg_t expect_gun(input logic [63:0] code);
		gun_cfg_t g = '{gun_type: 1'b0, sensor_delay: 8'(`GUN_DELAY_DEFAULT)};
		for (int i = 0; i < 5; i++) begin
			if (gun_id[i] == code) g = gun_cfg_t'(gun_val[i]);
		end
		return g;
	endfunction

	//////////////////////////////////////////////////
	// Scenarios
	//////////////////////////////////////////////////
	task automatic load_cart();
		ctrl_reg_t   ctrl;
		logic [63:0] code;
		logic [31:0] rdata;
		status_t     st;
		int          pick;
		foreach (img[i]) img[i] = 8'($urandom);
		pick = $urandom_range(0, 2);
		if (pick == 0) code = quirk_id[$urandom_range(0, 23)];
		else if (pick == 1) code = gun_id[$urandom_range(0, 4)];
		else for (int i = 0; i < 8; i++) code[8*i +: 8] = 8'($urandom_range(32, 126));
		for (int i = 0; i < 8; i++) img['h183 + i] = code[63 - 8*i -: 8];  // Odd start
		for (int a = `HDR_REGION_ADDR0; a <= `HDR_REGION_ADDR1; a++) img[a] = region_char();
		ctrl = '0;
		ctrl.manual_region = region_t'(2'($urandom_range(0, 2)));
		ctrl.auto_region   = 1'($urandom_range(0, 1));
		ctrl.policy        = region_policy_t'(2'($urandom_range(0, 3)));
		ctrl.cart_dl       = 1'b1;
		cart_mode = 1'b1;
		apb_write(`REG_CTRL, 32'(ctrl));
		apb_write(`REG_ADDR, IMG_BASE);
		for (int a = IMG_BASE; a <= `HDR_READY_ADDR; a += 2) begin
			rom_expect.push_back({`CART_ADDR_W'(a), img[a + 1], img[a]});
			apb_write(`REG_DATA, {16'h0, img[a + 1], img[a]});
			if (a == IMG_BASE) begin
				// First word drops the previous cartridge's results
				apb_read(`REG_STATUS, rdata);
				st = status_t'(rdata[$bits(status_t)-1:0]);
				check_region(st.region_valid, st.region, 1'b0, JP);
				check_quirks(st.quirks, '0);
			end
		end
		ctrl.cart_dl = 1'b0;
		apb_write(`REG_CTRL, 32'(ctrl));
		cart_mode = 1'b0;
		apb_read(`REG_STATUS, rdata);
		st = status_t'(rdata[$bits(status_t)-1:0]);
		check_region(st.region_valid, st.region, 1'b1,
			ctrl.auto_region ? expect_region(ctrl.policy) : ctrl.manual_region);
		check_quirks(st.quirks, expect_quirks(code));
		apb_read(`REG_GUN, rdata);
		check_gun(gun_cfg_t'(rdata[$bits(gun_cfg_t)-1:0]), expect_gun(code));
	endtask

	// Bottom half of each 32-bit field at the lower offset
	task automatic write_cheat_word(input int base, input logic [3:0] ofs,
			input cheat_fields_t rec);
		logic [31:0] fld;
		fld = 32'(rec >> (32 * (3 - ofs[3:2])));
		apb_write(`REG_ADDR, base + ofs);
		apb_write(`REG_DATA, {16'h0, ofs[1] ? fld[31:16] : fld[15:0]});
	endtask

	task automatic load_cheats();
		ctrl_reg_t     ctrl;
		cheat_fields_t rec;
		logic [3:0]    ofs [7];
		logic [3:0]    tmp;
		logic [31:0]   rdata;
		status_t       st;
		int            j;
		int            waits;
		ctrl = '0;
		ctrl.code_dl = 1'b1;
		apb_write(`REG_CTRL, 32'(ctrl));
		for (int r = 0; r < CHEAT_RECS; r++) begin
			rec = {$urandom, $urandom, $urandom, $urandom};
			for (int k = 0; k < 7; k++) ofs[k] = 4'(2 * k);
			for (int k = 6; k > 0; k--) begin  // Closing slot 0xE always goes last
				j      = $urandom_range(0, k);
				tmp    = ofs[k];
				ofs[k] = ofs[j];
				ofs[j] = tmp;
			end
			for (int k = 0; k < 7; k++) write_cheat_word('h1000 + 16 * r, ofs[k], rec);
			write_cheat_word('h1000 + 16 * r, `CHEAT_LAST_OFS, rec);
			waits = 0;
			@(negedge clk_sys);
			while (!cheat_valid) begin
				if (waits == TIMEOUT) timeout_abort("cheat_valid");
				waits++;
				@(negedge clk_sys);
			end
			check_cheat(cheat, rec);
		end
		ctrl.code_dl = 1'b0;
		apb_write(`REG_CTRL, 32'(ctrl));
		apb_read(`REG_STATUS, rdata);
		st = status_t'(rdata[$bits(status_t)-1:0]);
		check_count("cheat_count", st.cheat_count, 8'(CHEAT_RECS));
		check_count("cheat_valid pulses", 8'(pulse_cnt), 8'(CHEAT_RECS));
	endtask

	task automatic access_errors();
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, 'h14, 32'h0, rdata, err);
		check_flag("pslverr", err, 1'b1);
		apb_xfer(1'b1, 'h20, $urandom, rdata, err);
		check_flag("pslverr", err, 1'b1);
		apb_xfer(1'b0, `REG_GUN, 32'h0, rdata, err);  // Mapped read stays clean
		check_flag("pslverr", err, 1'b0);
	endtask

	initial begin : main_seq
		int waits;
		void'($urandom(32'h2043));
		RESET     = 1'b1;
		apb_req   = '0;
		rom_ack   = 1'b0;
		cart_mode = 1'b0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		for (int n = 0; n < CART_LOADS; n++) load_cart();
		load_cheats();
		access_errors();
		waits = 0;
		while (rom_req !== rom_ack) begin
			if (waits == TIMEOUT) timeout_abort("the last ROM acknowledge");
			waits++;
			@(negedge clk_sys);
		end
		repeat (2) @(negedge clk_sys);
		if (rom_expect.size() != 0) begin
			err_cnt++;
			$display("%0d cart words never reached the ROM port", rom_expect.size());
		end
		finish_run();
	end

endmodule

`default_nettype wire
